/* hdl/rob_macros.svh */
// Reorder buffer sizing constants shared by the packages and the RTL

`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// Number of response slots in the circular buffer
`define ROB_DEPTH 16

// log2 of the depth, width of a slot index
`define ROB_IDX_W 4

// Transaction ID width on the request and response channels
`define ID_W 3

// Burst length field, beats minus one
`define LEN_W 3

// Destination field width
`define DEST_W 4

// Response payload width
`define DATA_W 32

// Transactions allowed in flight per ID
// A further request on that ID waits for a last beat to leave
`define MAX_TXNS_PER_ID 4

`endif

/* hdl/rob_chan_pkg.sv */
// Field types of the request and response channels at the reorder buffer ports

`include "rob_macros.svh"

package rob_chan_pkg;

  // Transaction ID, carried on the request and returned with every beat
  typedef logic [`ID_W-1:0] ax_id_t;

  // Burst length as beats minus one, so zero means a single beat
  typedef logic [`LEN_W-1:0] ax_len_t;

  // Destination of the request on the network side
  typedef logic [`DEST_W-1:0] dest_t;

  // One beat of response data
  typedef logic [`DATA_W-1:0] rsp_data_t;

endpackage

/* hdl/rob_buf_pkg.sv */
// Internal types of the reorder buffer: slot index, counters and stored metadata

`include "rob_macros.svh"

package rob_buf_pkg;

  import rob_chan_pkg::*;

  // Slot index into the circular buffer
  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

  // Free slot count, one bit wider so a completely empty buffer fits
  typedef logic [`ROB_IDX_W:0] rob_cnt_t;

  // Outstanding transactions of one ID, must reach MAX_TXNS_PER_ID
  typedef logic [$clog2(`MAX_TXNS_PER_ID):0] txn_cnt_t;

  // Metadata kept next to each beat
  typedef struct packed {
    ax_id_t id;
    logic   last;
  } rsp_meta_t;

endpackage

/* hdl/rob_storage.sv */
// Reorder buffer slot array, written at any slot and read at the head

`timescale 1ns/100ps

`include "rob_macros.svh"

module rob_storage
  import rob_buf_pkg::*;
#(
  // Payload stored per slot
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     wr_en_i,
  input  rob_idx_t wr_idx_i,
  input  payload_t wr_data_i,
  input  rob_idx_t rd_idx_i,
  output payload_t rd_data_o
);

  payload_t mem_q [`ROB_DEPTH];

  // Beats land in their reserved slot, whatever the arrival order
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Head entry is visible in the same cycle
  assign rd_data_o = mem_q[rd_idx_i];

endmodule

/* hdl/rob_id_counters.sv */
// Per-ID outstanding transaction counters with lookup, push and pop

`timescale 1ns/100ps

`include "rob_macros.svh"

module rob_id_counters
  import rob_chan_pkg::*;
  import rob_buf_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  ax_id_t lookup_id_i,
  output logic   full_o,
  input  logic   push_i,
  input  ax_id_t push_id_i,
  input  logic   pop_i,
  input  ax_id_t pop_id_i
);

  localparam int unsigned NUM_IDS = 2 ** `ID_W;

  txn_cnt_t cnt_q [NUM_IDS];
  txn_cnt_t cnt_d [NUM_IDS];

  // Next count per ID, a push and a pop on the same ID leave it unchanged
  always_comb begin
    logic push_hit;
    logic pop_hit;
    for (int i = 0; i < NUM_IDS; i++) begin
      push_hit = push_i && (push_id_i == ax_id_t'(i));
      pop_hit  = pop_i && (pop_id_i == ax_id_t'(i));
      cnt_d[i] = cnt_q[i];
      if (push_hit && !pop_hit) begin
        cnt_d[i] = cnt_q[i] + txn_cnt_t'(1);
      end else if (pop_hit && !push_hit) begin
        cnt_d[i] = cnt_q[i] - txn_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // Requested ID has used up its allowance
  assign full_o = (cnt_q[lookup_id_i] == txn_cnt_t'(`MAX_TXNS_PER_ID));

endmodule

/* hdl/rob_ctrl.sv */
// Reorder buffer control: slot allocation, valid tracking and in-order release

`timescale 1ns/100ps

`include "rob_macros.svh"

module rob_ctrl
  import rob_chan_pkg::*;
  import rob_buf_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Request side
  input  logic     ax_valid_i,
  input  logic     ax_ready_i,
  input  ax_len_t  ax_len_i,
  input  logic     id_full_i,
  output logic     ax_valid_o,
  output logic     ax_ready_o,
  output rob_idx_t ax_rob_idx_o,
  // Response input
  input  logic     rsp_valid_i,
  input  rob_idx_t rsp_rob_idx_i,
  output logic     rsp_ready_o,
  output logic     wr_en_o,
  // Response output
  output rob_idx_t head_idx_o,
  input  logic     rsp_last_i,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  // ID counter updates
  output logic     push_o,
  output logic     pop_o
);

  rob_idx_t             head_q;
  rob_idx_t             tail_q;
  rob_cnt_t             free_cnt_q;
  logic [`ROB_DEPTH-1:0] slot_vld_q;
  logic                 rsp_rdy_q;

  rob_cnt_t need;
  logic     room;
  logic     accept;
  logic     release_beat;

  // A burst of len+1 beats takes that many consecutive slots
  assign need = rob_cnt_t'(ax_len_i) + rob_cnt_t'(1);
  assign room = (free_cnt_q >= need) && !id_full_i;

  assign ax_valid_o   = ax_valid_i && room;
  assign ax_ready_o   = ax_valid_o && ax_ready_i;
  assign ax_rob_idx_o = tail_q;
  assign accept       = ax_ready_o;

  // Every beat already owns a slot, so the input never stalls once out of reset
  assign rsp_ready_o = rsp_rdy_q;
  assign wr_en_o     = rsp_valid_i && rsp_rdy_q;

  // Release strictly from the head
  assign head_idx_o   = head_q;
  assign rsp_valid_o  = slot_vld_q[head_q];
  assign release_beat = rsp_valid_o && rsp_ready_i;

  assign push_o = accept;
  assign pop_o  = release_beat && rsp_last_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_rdy_q <= 1'b0;
    end else begin
      rsp_rdy_q <= 1'b1;
    end
  end

  // Tail moves past the reserved block on each accepted request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tail_q <= '0;
    end else if (accept) begin
      tail_q <= tail_q + rob_idx_t'(need);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q <= '0;
    end else if (release_beat) begin
      head_q <= head_q + rob_idx_t'(1);
    end
  end

  // Accept and release may coincide
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      free_cnt_q <= rob_cnt_t'(`ROB_DEPTH);
    end else begin
      free_cnt_q <= free_cnt_q
                  - (accept ? need : rob_cnt_t'(0))
                  + (release_beat ? rob_cnt_t'(1) : rob_cnt_t'(0));
    end
  end

  // Slot valid bits
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_vld_q <= '0;
    end else begin
      if (release_beat) begin
        slot_vld_q[head_q] <= 1'b0;
      end
      if (wr_en_o) begin
        slot_vld_q[rsp_rob_idx_i] <= 1'b1;
      end
    end
  end

endmodule

/* hdl/rob_unit.sv */
// Reorder buffer top level, returns out-of-order responses in request order

`timescale 1ns/100ps

module rob_unit
  import rob_chan_pkg::*;
  import rob_buf_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Request from the local port
  input  logic      ax_valid_i,
  output logic      ax_ready_o,
  input  ax_len_t   ax_len_i,
  input  ax_id_t    ax_id_i,
  input  dest_t     ax_dest_i,
  // Request towards the network
  output logic      ax_valid_o,
  input  logic      ax_ready_i,
  output rob_idx_t  ax_rob_idx_o,
  output dest_t     ax_dest_o,
  output ax_id_t    ax_id_o,
  output ax_len_t   ax_len_o,
  // Responses from the network, any order
  input  logic      rsp_valid_i,
  output logic      rsp_ready_o,
  input  rob_idx_t  rsp_rob_idx_i,
  input  rsp_data_t rsp_data_i,
  input  ax_id_t    rsp_id_i,
  input  logic      rsp_last_i,
  // Responses to the local port, request order
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i,
  output rsp_data_t rsp_data_o,
  output ax_id_t    rsp_id_o,
  output logic      rsp_last_o
);

  logic      wr_en;
  logic      id_full;
  logic      push;
  logic      pop;
  rob_idx_t  head_idx;
  rsp_meta_t wr_meta;
  rsp_meta_t head_meta;

  // Request fields go downstream unchanged next to the slot index
  assign ax_id_o   = ax_id_i;
  assign ax_dest_o = ax_dest_i;
  assign ax_len_o  = ax_len_i;

  assign wr_meta.id   = rsp_id_i;
  assign wr_meta.last = rsp_last_i;

  assign rsp_id_o   = head_meta.id;
  assign rsp_last_o = head_meta.last;

  rob_ctrl u_ctrl (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .ax_valid_i    ( ax_valid_i     ),
    .ax_ready_i    ( ax_ready_i     ),
    .ax_len_i      ( ax_len_i       ),
    .id_full_i     ( id_full        ),
    .ax_valid_o    ( ax_valid_o     ),
    .ax_ready_o    ( ax_ready_o     ),
    .ax_rob_idx_o  ( ax_rob_idx_o   ),
    .rsp_valid_i   ( rsp_valid_i    ),
    .rsp_rob_idx_i ( rsp_rob_idx_i  ),
    .rsp_ready_o   ( rsp_ready_o    ),
    .wr_en_o       ( wr_en          ),
    .head_idx_o    ( head_idx       ),
    .rsp_last_i    ( head_meta.last ),
    .rsp_valid_o   ( rsp_valid_o    ),
    .rsp_ready_i   ( rsp_ready_i    ),
    .push_o        ( push           ),
    .pop_o         ( pop            )
  );

  // Pop uses the ID of the beat leaving at the head
  rob_id_counters u_id_counters (
    .clk_i       ( clk_i        ),
    .rst_n_i     ( rst_n_i      ),
    .lookup_id_i ( ax_id_i      ),
    .full_o      ( id_full      ),
    .push_i      ( push         ),
    .push_id_i   ( ax_id_i      ),
    .pop_i       ( pop          ),
    .pop_id_i    ( head_meta.id )
  );

  rob_storage #(
    .payload_t ( rsp_data_t )
  ) u_data_store (
    .clk_i     ( clk_i         ),
    .wr_en_i   ( wr_en         ),
    .wr_idx_i  ( rsp_rob_idx_i ),
    .wr_data_i ( rsp_data_i    ),
    .rd_idx_i  ( head_idx      ),
    .rd_data_o ( rsp_data_o    )
  );

  rob_storage #(
    .payload_t ( rsp_meta_t )
  ) u_meta_store (
    .clk_i     ( clk_i         ),
    .wr_en_i   ( wr_en         ),
    .wr_idx_i  ( rsp_rob_idx_i ),
    .wr_data_i ( wr_meta       ),
    .rd_idx_i  ( head_idx      ),
    .rd_data_o ( head_meta     )
  );

endmodule

/* verif/tb_clk_gen.sv */
// Testbench clock and reset source, free running clock and a reset held for a few cycles

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lines up with the other inputs, just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

/* verif/tb_rob_unit.sv */
// Reorder buffer testbench with an out-of-order responder, a release scoreboard and assertions

`timescale 1ns/100ps

`include "rob_macros.svh"

module tb_rob_unit
  import rob_chan_pkg::*;
  import rob_buf_pkg::*;
();

  typedef struct packed {
    rob_idx_t    base;
    ax_len_t     len;
    ax_id_t      id;
    logic [15:0] serial;
  } txn_t;

  typedef struct packed {
    rsp_data_t data;
    ax_id_t    id;
    logic      last;
  } beat_t;

  localparam int CYCLE_LIMIT = 4000;

  logic      clk, rst_n;
  logic      ax_valid_i, ax_ready_o, ax_valid_o, ax_ready_i;
  ax_len_t   ax_len_i, ax_len_o;
  ax_id_t    ax_id_i, ax_id_o;
  dest_t     ax_dest_i, ax_dest_o;
  rob_idx_t  ax_rob_idx_o, rsp_rob_idx_i;
  logic      rsp_valid_i, rsp_ready_o, rsp_last_i;
  rsp_data_t rsp_data_i, rsp_data_o;
  ax_id_t    rsp_id_i, rsp_id_o;
  logic      rsp_valid_o, rsp_ready_i, rsp_last_o;

  integer seed       = 32'h604e;
  integer ready_seed = 32'h604e + 1;
  int     cycle_cnt  = 0;

  // Reference model updated at the falling edge before the handshake edge
  txn_t        pending_q[$];
  beat_t       exp_q[$];
  rob_idx_t    tail_pred;
  int          free_pred;
  int          id_cnt_pred[2 ** `ID_W];
  logic [15:0] serial_cnt;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  rob_unit u_dut (.*, .clk_i(clk), .rst_n_i(rst_n));

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Serial number in the top half so a stale slot cannot pass for a new beat
  function automatic rsp_data_t beat_data(input logic [15:0] serial, input rob_idx_t base,
                                          input ax_len_t k);
    return {serial, 4'hc, base, 5'b0, k};
  endfunction

  task automatic send_request(input ax_len_t len, input ax_id_t id);
    ax_valid_i = 1'b1;
    ax_len_i   = len;
    ax_id_i    = id;
    ax_dest_i  = dest_t'(len + id);
    // Downstream holds off the first cycle of every offer
    ax_ready_i = 1'b0;
    @(posedge clk);
    #2;
    ax_ready_i = 1'b1;
    @(negedge clk);
    while (!ax_ready_o) @(negedge clk);
    @(posedge clk);
    #2;
    ax_valid_i = 1'b0;
  endtask

  task automatic send_beat(input rob_idx_t idx, input rsp_data_t data, input ax_id_t id,
                           input logic last);
    rsp_valid_i   = 1'b1;
    rsp_rob_idx_i = idx;
    rsp_data_i    = data;
    rsp_id_i      = id;
    rsp_last_i    = last;
    @(posedge clk);
    #2;
    rsp_valid_i = 1'b0;
  endtask

  // Answer n recorded transactions newest first or in random order
  task automatic respond_some(input int n, input logic newest_first);
    int   pick;
    int   k;
    txn_t t;
    for (int i = 0; i < n && pending_q.size() > 0; i++) begin
      if (newest_first) pick = pending_q.size() - 1;
      else pick = int'($unsigned($random(seed)) % pending_q.size());
      t = pending_q[pick];
      pending_q.delete(pick);
      for (int j = 0; j <= int'(t.len); j++) begin
        k = newest_first ? int'(t.len) - j : j;
        send_beat(t.base + rob_idx_t'(k), beat_data(t.serial, t.base, ax_len_t'(k)), t.id,
                  k == int'(t.len));
      end
    end
  endtask

  task automatic drain();
    respond_some(pending_q.size(), 1'b0);
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Random back-pressure on the released stream
  initial begin
    rsp_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      rsp_ready_i = ($random(ready_seed) & 3) != 0;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      stop_with_error($sformatf("Timeout: the run did not finish within %0d cycles",
                                CYCLE_LIMIT));
    end
  end

  always @(negedge clk) begin : monitor
    txn_t  t;
    beat_t b;
    logic  exp_valid;
    logic  exp_ready;
    if (rst_n) begin
      exp_valid = ax_valid_i && (free_pred >= int'(ax_len_i) + 1) &&
                  (id_cnt_pred[ax_id_i] < `MAX_TXNS_PER_ID);
      exp_ready = exp_valid && ax_ready_i;
      assert (ax_valid_o == exp_valid) else stop_with_error($sformatf(
        "FAIL %0t: ax_valid_o is %0b, expected %0b", $time, ax_valid_o, exp_valid));
      assert (ax_ready_o == exp_ready) else stop_with_error($sformatf(
        "FAIL %0t: ax_ready_o is %0b, expected %0b", $time, ax_ready_o, exp_ready));
      if (rsp_valid_i) begin
        assert (rsp_ready_o) else stop_with_error($sformatf(
          "FAIL %0t: rsp_ready_o is low while a response beat arrives", $time));
      end
      if (exp_ready) begin
        assert (ax_rob_idx_o == tail_pred) else stop_with_error($sformatf(
          "FAIL %0t: ax_rob_idx_o is %0d, expected %0d", $time, ax_rob_idx_o, tail_pred));
        assert (ax_id_o == ax_id_i && ax_len_o == ax_len_i && ax_dest_o == ax_dest_i)
          else stop_with_error($sformatf(
            "FAIL %0t: forwarded %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
            ax_id_o, ax_len_o, ax_dest_o, ax_id_i, ax_len_i, ax_dest_i));
        t = '{base: tail_pred, len: ax_len_i, id: ax_id_i, serial: serial_cnt};
        pending_q.push_back(t);
        for (int k = 0; k <= int'(ax_len_i); k++) begin
          b.data = beat_data(serial_cnt, tail_pred, ax_len_t'(k));
          b.id   = ax_id_i;
          b.last = (k == int'(ax_len_i));
          exp_q.push_back(b);
        end
        tail_pred = tail_pred + rob_idx_t'(ax_len_i) + rob_idx_t'(1);
        free_pred = free_pred - int'(ax_len_i) - 1;
        id_cnt_pred[ax_id_i]++;
        serial_cnt++;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        assert (exp_q.size() > 0)
          else stop_with_error("A beat was released that was never requested");
        b = exp_q.pop_front();
        assert (rsp_data_o == b.data && rsp_id_o == b.id && rsp_last_o == b.last)
          else stop_with_error($sformatf("FAIL %0t: released %h/%0d/%0b, expected %h/%0d/%0b",
            $time, rsp_data_o, rsp_id_o, rsp_last_o, b.data, b.id, b.last));
        free_pred++;
        if (b.last) id_cnt_pred[b.id]--;
      end
    end
  end

  // Head beat holds still while the local port stalls
  assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_data_o) &&
                                        $stable(rsp_id_o) && $stable(rsp_last_o)))
    else stop_with_error($sformatf("FAIL %0t: response output changed while stalled", $time));

  initial begin
    int      nreq;
    ax_len_t len;
    ax_id_t  id;
    {ax_valid_i, ax_ready_i, ax_len_i, ax_id_i, ax_dest_i} = '0;
    {rsp_valid_i, rsp_rob_idx_i, rsp_data_i, rsp_id_i, rsp_last_i} = '0;
    tail_pred  = '0;
    free_pred  = `ROB_DEPTH;
    serial_cnt = '0;
    foreach (id_cnt_pred[i]) id_cnt_pred[i] = 0;

    @(posedge rst_n);
    @(posedge clk);
    @(negedge clk);
    assert (!ax_valid_o && !rsp_valid_o && rsp_ready_o) else stop_with_error($sformatf(
      "FAIL %0t: outputs after reset are %0b/%0b/%0b", $time,
      ax_valid_o, rsp_valid_o, rsp_ready_o));
    @(posedge clk);
    #2;

    // Mixed bursts answered in part and alternately newest first or at random
    for (int r = 0; r < 20; r++) begin
      nreq = 1 + int'($unsigned($random(seed)) % 3);
      for (int q = 0; q < nreq; q++) begin
        len = ax_len_t'($random(seed));
        id  = ax_id_t'($random(seed));
        if (free_pred >= int'(len) + 1 && id_cnt_pred[id] < `MAX_TXNS_PER_ID) begin
          send_request(len, id);
        end
      end
      if (pending_q.size() > 0)
        respond_some(1 + int'($unsigned($random(seed)) % pending_q.size()), r[0]);
    end
    drain();

    // Third request waits in a full buffer for the head transaction to leave
    send_request(3'd7, 3'd0);
    send_request(3'd7, 3'd1);
    fork
      send_request(3'd3, 3'd2);
      begin
        repeat (4) begin
          @(posedge clk);
          #2;
        end
        respond_some(2, 1'b1);
      end
    join
    drain();

    // ID 5 is refused at its limit while ID 3 goes through
    for (int q = 0; q < `MAX_TXNS_PER_ID; q++) send_request(3'd0, 3'd5);
    ax_valid_i = 1'b1;
    ax_len_i   = 3'd0;
    ax_id_i    = 3'd5;
    ax_ready_i = 1'b1;
    repeat (4) begin
      @(posedge clk);
      #2;
    end
    ax_valid_i = 1'b0;
    send_request(3'd2, 3'd3);
    fork
      send_request(3'd0, 3'd5);
      respond_some(pending_q.size(), 1'b0);
    join
    drain();

    if (!rsp_valid_o) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_with_error($sformatf("FAIL %0t: rsp_valid_o is still high after the last beat left",
                                $time));
    end
  end

endmodule

/* rob_unit.f */
+incdir+hdl
hdl/rob_chan_pkg.sv
hdl/rob_buf_pkg.sv
hdl/rob_storage.sv
hdl/rob_id_counters.sv
hdl/rob_ctrl.sv
hdl/rob_unit.sv
verif/tb_clk_gen.sv
verif/tb_rob_unit.sv

/* Makefile */
# Verilator build and run of the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_rob_unit
FILELIST  ?= rob_unit.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= ALL TESTS PASSED

SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hdl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
